// File: project.f
src/seg_pkg.sv
src/scan_pkg.sv
src/scan_if.sv
src/refresh_divider.sv
src/scan_sequencer.sv
src/glyph_encoder.sv
src/seg_driver.sv
src/seg_display_top.sv
verif/seg_display_tb.sv

// File: Bender.yml
package:
  name: seg_display

sources:
  # Packages first, then the interface and the modules bottom up
  - files:
      - src/seg_pkg.sv
      - src/scan_pkg.sv
      - src/scan_if.sv
      - src/refresh_divider.sv
      - src/scan_sequencer.sv
      - src/glyph_encoder.sv
      - src/seg_driver.sv
      - src/seg_display_top.sv

  # Testbench, only in simulation
  - target: test
    files:
      - verif/seg_display_tb.sv

// File: verif/seg_display_tb.sv
/*
 * Random-stimulus testbench for the eight-digit seven-segment display controller.
 * A cycle-accurate reference model predicts both pin groups every cycle while
 * value and mask change at random points, mid-frame included.
 */
`timescale 1ns/1ps

module seg_display_tb;
	import seg_pkg::*;
	import scan_pkg::*;

	localparam int CLK_HALF     = 20;   // 40 ns clock period
	localparam int TICK_DIV     = 4;    // Short refresh tick keeps frames at 256 cycles
	localparam int RESET_CYCLES = 2;
	localparam int NUM_FRAMES   = 20;
	localparam int FRAME_CYCLES = num_digits * slot_ticks * TICK_DIV;
	localparam int CYCLE_LIMIT  = NUM_FRAMES * FRAME_CYCLES + 64; // Margin covers reset and startup
	localparam int LIT_CYCLES   = (slot_ticks - blank_ticks) * TICK_DIV; // Length of one lit run

	// Independent copy of the hex character set, active low, index is the nibble
	localparam logic [7:0] ref_glyphs [16] = '{
		8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
		8'h80, 8'h90, 8'h88, 8'h83, 8'hA7, 8'hA1, 8'h84, 8'h8E
	};

	logic                  sys_clk;
	logic                  sys_rst_n;
	logic [val_w-1:0]      seg_val;
	logic [num_digits-1:0] seg_sel;
	logic [7:0]            seg_val_out;
	logic [7:0]            seg_sel_out;

	logic [15:0]      lfsr;         // Random source state
	int               value_errors; // Wrong values seen at the pins
	int               other_errors; // Timeout and similar failures
	int               checks;
	int               cycles;       // Falling edges since the start
	int               run_len;      // Length of the current lit run
	int               frames_seen;  // Frame starts predicted by the model

	// Model state, all of it updated on the rising edge
	int               m_div;   // Position inside the refresh tick period
	int               m_slot;  // Ticks elapsed in the current slot
	int               m_digit; // Slot being scanned
	logic             m_frame; // Frame start pulse
	logic [val_w-1:0] lat_val; // Value frozen for the frame
	logic [7:0]       lat_sel; // Mask frozen for the frame
	logic [7:0]       exp_val; // Predicted cathodes
	logic [7:0]       exp_sel; // Predicted anodes

	seg_display_top #(
		.tick_div (TICK_DIV)
	) UUT (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.seg_val     (seg_val),
		.seg_sel     (seg_sel),
		.seg_val_out (seg_val_out),
		.seg_sel_out (seg_sel_out)
	);

	initial sys_clk = 1'b0;
	always #CLK_HALF sys_clk = ~sys_clk;

	// 16-bit Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	// Collects n random bits, one LFSR step per bit
	task automatic take_bits(input int n, output logic [31:0] bits);
		bits = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_step(lfsr);
			bits = {bits[30:0], lfsr[0]};
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			$display("** Error %s: expected %h, actual %h at %0t ns", name, expected, actual, $time);
			value_errors++;
		end
	endtask

	// Reference model of the scan timing, frame latch and pin register
	always @(posedge sys_clk) begin : ref_model
		logic       tick_now;
		logic [3:0] nib;
		if (!sys_rst_n) begin
			m_div       = 0;
			m_slot      = 0;
			m_digit     = 0;
			m_frame     = 1'b1; // First frame starts right after reset
			lat_val     = '0;
			lat_sel     = '0;
			exp_val     = 8'hFF;
			exp_sel     = 8'hFF;
			frames_seen = 0;
		end else begin
			tick_now = (m_div == TICK_DIV - 1);
			// Pins show the slot and frame as they stood before this edge
			if (m_slot >= blank_ticks && lat_sel[num_digits-1-m_digit]) begin
				nib     = lat_val[nibble_w*(num_digits-1-m_digit) +: nibble_w];
				exp_val = ref_glyphs[nib] | 8'h80; // Decimal point stays dark
				exp_sel = ~(8'h01 << m_digit);
			end else begin
				exp_val = 8'hFF;
				exp_sel = 8'hFF;
			end
			if (m_frame) begin
				lat_val = seg_val; // Live inputs only count at a frame start
				lat_sel = seg_sel;
			end
			m_frame = 1'b0;
			if (tick_now) begin
				if (m_slot == slot_ticks - 1) begin
					m_slot  = 0;
					m_frame = (m_digit == num_digits - 1); // Wrap to slot 0 opens a frame
					m_digit = (m_digit + 1) % num_digits;
					if (m_frame)
						frames_seen++;
				end else begin
					m_slot++;
				end
			end
			m_div = tick_now ? 0 : m_div + 1;
		end
	end

	initial begin : stimulus
		logic [31:0] pick;
		lfsr         = 16'd93;
		value_errors = 0;
		other_errors = 0;
		checks       = 0;
		cycles       = 0;
		run_len      = 0;
		sys_rst_n    = 1'b0;
		take_bits(val_w, pick);
		seg_val = pick;
		take_bits(num_digits, pick);
		seg_sel = pick[num_digits-1:0];

		while (frames_seen < NUM_FRAMES && cycles < CYCLE_LIMIT) begin
			@(negedge sys_clk);
			cycles++;
			check_value("cathodes", exp_val, seg_val_out);
			check_value("anodes", exp_sel, seg_sel_out);
			check_value("exclusive anode", 32'd1, {31'b0, $countones(~seg_sel_out) <= 1});
			// Every lit run lasts the lit part of one slot
			if (seg_sel_out != 8'hFF) begin
				run_len++;
			end else if (run_len != 0) begin
				check_value("lit length", LIT_CYCLES, run_len);
				run_len = 0;
			end
			if (cycles == RESET_CYCLES) begin
				sys_rst_n = 1'b1;
			end else if (sys_rst_n) begin
				take_bits(5, pick); // About eight value changes per frame
				if (pick[4:0] == 5'd0) begin
					take_bits(val_w, pick);
					seg_val = pick;
				end
				take_bits(5, pick);
				if (pick[4:0] == 5'd0) begin
					take_bits(num_digits, pick);
					seg_sel = pick[num_digits-1:0];
				end
			end
		end

		if (frames_seen < NUM_FRAMES) begin
			$display("Run stopped at the cycle limit of %0d with only %0d of %0d frames done",
				CYCLE_LIMIT, frames_seen, NUM_FRAMES);
			other_errors++;
		end
		$display("Checks: %0d, value errors: %0d, other errors: %0d",
			checks, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// File: src/seg_display_top.sv
/*
 * Eight-digit multiplexed seven-segment display controller.
 * Takes a 32-bit hex value and a digit mask as levels and scans them out
 * on active-low cathode and anode pins, refreshing every tick_div cycles.
 */
`timescale 1ns/1ps

module seg_display_top #(
	parameter int tick_div = scan_pkg::default_tick_div // System clocks per refresh tick
) (
	input  logic                           sys_clk,
	input  logic                           sys_rst_n,
	input  logic [seg_pkg::val_w-1:0]      seg_val,    // Eight hex nibbles, leftmost is MSB
	input  logic [seg_pkg::num_digits-1:0] seg_sel,    // Digit enables, bit 7 for slot 0
	output logic [7:0]                     seg_val_out, // Cathodes, active low
	output logic [seg_pkg::num_digits-1:0] seg_sel_out  // Anodes, active low
);
	import seg_pkg::*;

	glyph_t [num_digits-1:0] glyphs;   // Decoded patterns in slot order
	logic   [num_digits-1:0] digit_en; // Frame mask in slot order

	// Scan position shared by all three blocks
	scan_if scan ();

	// Timing and digit position
	scan_sequencer #(
		.tick_div (tick_div)
	) u_scan_sequencer (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.scan      (scan)
	);

	// Frame capture and hex decoding
	glyph_encoder u_glyph_encoder (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.seg_val   (seg_val),
		.seg_sel   (seg_sel),
		.scan      (scan),
		.glyphs    (glyphs),
		.digit_en  (digit_en)
	);

	// Pin register stage
	seg_driver u_seg_driver (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.scan        (scan),
		.glyphs      (glyphs),
		.digit_en    (digit_en),
		.seg_val_out (seg_val_out),
		.seg_sel_out (seg_sel_out)
	);

endmodule

// File: src/seg_driver.sv
/*
 * Drives the segment and anode pins from the scan position and the decoded glyphs.
 * Pins are registered and active low with one digit lit at a time.
 * Blank phase and masked digits leave every anode and segment off.
 */
`timescale 1ns/1ps

module seg_driver (
	input  logic                              sys_clk,
	input  logic                              sys_rst_n,
	scan_if.driver                            scan,
	input  seg_pkg::glyph_t [seg_pkg::num_digits-1:0] glyphs,
	input  logic [seg_pkg::num_digits-1:0]    digit_en,
	output logic [7:0]                        seg_val_out, // Active low cathodes
	output logic [7:0]                        seg_sel_out  // Active low anodes with bit i for slot i
);
	import seg_pkg::*;
	import scan_pkg::*;

	logic                  show;     // Current slot should be lit
	glyph_t                cur_glyph; // Pattern for the current slot
	logic [num_digits-1:0] cur_sel;   // Active low one-cold anode pattern

	// Light only in the lit phase and only if the frame mask enables this slot
	assign show      = (scan.phase == phase_lit) && digit_en[scan.digit];
	assign cur_glyph = glyphs[scan.digit];
	assign cur_sel   = ~(num_digits'(1) << scan.digit);

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			seg_val_out <= glyph_off;
			seg_sel_out <= '1; // Every digit off
		end else if (show) begin
			seg_val_out <= cur_glyph;
			seg_sel_out <= cur_sel;
		end else begin
			seg_val_out <= glyph_off; // Cathodes go dark together with the anodes
			seg_sel_out <= '1;
		end
	end

	// Two anodes low at once would show one glyph on two digits
	one_anode_at_most : assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		$countones(~seg_sel_out) <= 1
	) else $error("More than one anode driven low");

endmodule

// File: src/glyph_encoder.sv
/*
 * Holds the value and digit mask for one whole frame and decodes them per slot.
 * Inputs are sampled only on frame_start so a digit never changes mid-frame.
 * Outputs are in slot order with slot i showing nibble 7-i under mask bit 7-i.
 */
`timescale 1ns/1ps

module glyph_encoder (
	input  logic                              sys_clk,
	input  logic                              sys_rst_n,
	input  logic [seg_pkg::val_w-1:0]         seg_val,
	input  logic [seg_pkg::num_digits-1:0]    seg_sel,
	scan_if.encoder                           scan,
	output seg_pkg::glyph_t [seg_pkg::num_digits-1:0] glyphs,
	output logic [seg_pkg::num_digits-1:0]    digit_en
);
	import seg_pkg::*;

	logic [val_w-1:0]      val_q; // Value frozen for the current frame
	logic [num_digits-1:0] sel_q; // Digit mask frozen for the current frame

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			val_q <= '0;
			sel_q <= '0; // All digits off until the first capture
		end else if (scan.frame_start) begin
			val_q <= seg_val;
			sel_q <= seg_sel;
		end
	end

	// One decoder per slot
	// The most significant nibble goes to slot 0, the leftmost digit
	for (genvar i = 0; i < num_digits; i++) begin : g_slot
		logic [nibble_w-1:0] nib; // Nibble shown in this slot

		assign nib = val_q[nibble_w*(num_digits-1-i) +: nibble_w];

		// The decimal point is unused so bit 7 stays dark whatever the table holds
		assign glyphs[i] = {1'b1, hex_glyphs[nib][6:0]};

		assign digit_en[i] = sel_q[num_digits-1-i]; // Mask is reversed the same way
	end

endmodule

// File: src/scan_sequencer.sv
/*
 * Walks the display through its digit slots on refresh ticks.
 * Each slot opens with a short blank phase and then lights its digit.
 * Slot and frame boundaries are flagged as registered one-cycle pulses.
 */
`timescale 1ns/1ps

module scan_sequencer #(
	parameter int tick_div = scan_pkg::default_tick_div // Cycles per refresh tick
) (
	input  logic sys_clk,
	input  logic sys_rst_n,
	scan_if.sequencer scan
);
	import seg_pkg::*;
	import scan_pkg::*;

	logic                  tick;      // Refresh enable
	logic [slot_cnt_w-1:0] slot_cnt;  // Ticks elapsed in the current slot
	logic                  slot_end;  // This tick closes the slot
	logic                  blank_end; // This tick closes the blank phase

	refresh_divider #(
		.ratio (tick_div)
	) u_refresh_divider (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tick      (tick)
	);

	assign slot_end  = (slot_cnt == slot_cnt_w'(slot_ticks - 1));
	assign blank_end = (slot_cnt == slot_cnt_w'(blank_ticks - 1));

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			slot_cnt         <= '0;
			scan.digit       <= '0;
			scan.phase       <= phase_blank;
			scan.slot_start  <= 1'b0;
			scan.frame_start <= 1'b1; // First frame latches the inputs right after reset
		end else begin
			scan.slot_start  <= 1'b0; // Pulses by default
			scan.frame_start <= 1'b0;
			if (tick) begin
				if (slot_end) begin
					slot_cnt        <= '0;
					scan.digit      <= scan.digit + 1'b1; // Wraps from the last slot to 0
					scan.phase      <= phase_blank;
					scan.slot_start <= 1'b1;
					// Leaving the last slot means a new frame begins
					scan.frame_start <= (scan.digit == digit_w'(num_digits - 1));
				end else begin
					slot_cnt <= slot_cnt + 1'b1;
					if (blank_end) begin
						scan.phase <= phase_lit; // Blank time is over
					end
				end
			end
		end
	end

	// Digit position may only move together with the slot boundary flag
	digit_moves_on_slot : assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		$changed(scan.digit) |-> scan.slot_start
	) else $error("Digit index changed outside a slot start");

endmodule

// File: src/refresh_divider.sv
/*
 * Turns the system clock into a one-cycle refresh enable every ratio cycles.
 * Everything downstream stays on sys_clk and steps only when tick is high.
 */
`timescale 1ns/1ps

module refresh_divider #(
	parameter int ratio = scan_pkg::default_tick_div // Cycles per tick, at least 2
) (
	input  logic sys_clk,
	input  logic sys_rst_n,
	output logic tick
);

	logic [$clog2(ratio)-1:0] cnt; // Position inside the tick period

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			cnt <= '0;
		end else if (tick) begin
			cnt <= '0; // Period complete, start over
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// Tick on the last count of the period
	// The first tick therefore lands ratio-1 cycles after reset is released
	assign tick = (cnt == ($clog2(ratio))'(ratio - 1));

	// A tick must be a single cycle enable, never a level
	tick_single_cycle : assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		tick |=> !tick
	) else $error("Refresh tick held high for two cycles");

endmodule

// File: src/scan_if.sv
/*
 * Scan state bundle from the sequencer to the glyph encoder and the segment driver.
 * The sequencer owns every signal, the other two only listen.
 */
`timescale 1ns/1ps

interface scan_if;
	import seg_pkg::*;
	import scan_pkg::*;

	logic [digit_w-1:0] digit;       // Digit slot currently scanned
	scan_phase_e        phase;       // Blank or lit part of the slot
	logic               slot_start;  // One cycle pulse on entering a new slot
	logic               frame_start; // One cycle pulse on entering slot 0

	modport sequencer (
		output digit, phase, slot_start, frame_start
	);

	// The encoder only cares about frame boundaries
	modport encoder (
		input digit, phase, slot_start, frame_start
	);

	// The driver follows position and phase
	modport driver (
		input digit, phase, slot_start, frame_start
	);

endinterface

// File: src/scan_pkg.sv
/*
 * Refresh timing constants and the scan phase type.
 * Shared by the scan sequencer, the driver and the scan interface.
 */
package scan_pkg;

	// System clock cycles per refresh tick
	// At 50 MHz this gives an 8 kHz refresh tick
	localparam int default_tick_div = 6250;

	// Refresh ticks spent on each digit slot
	localparam int slot_ticks = 8;

	// Leading ticks of every slot kept dark so the previous digit cannot ghost
	localparam int blank_ticks = 1;

	// Width of the tick counter inside one slot
	localparam int slot_cnt_w = $clog2(slot_ticks);

	// Phase inside a digit slot
	typedef enum logic {
		phase_blank = 1'b0, // Anodes off while the segment lines settle
		phase_lit   = 1'b1  // Current digit is driven
	} scan_phase_e;

endpackage

// File: src/seg_pkg.sv
/*
 * Display geometry and glyph definitions for the eight-digit seven-segment display.
 * Imported by the encoder, the driver, the scan interface and the top level.
 */
package seg_pkg;

	localparam int num_digits = 8;                  // Digits on the board
	localparam int digit_w    = $clog2(num_digits); // Width of a digit slot index
	localparam int nibble_w   = 4;                  // One hex digit
	localparam int val_w      = num_digits * nibble_w; // Full display value

	// Active low segment pattern
	// Bit 7 is the decimal point, bits 0 to 6 are segments a to g
	typedef logic [7:0] glyph_t;

	// Hex character set, indexed by nibble value
	localparam glyph_t hex_glyphs [16] = '{
		8'hC0, // 0
		8'hF9, // 1
		8'hA4, // 2
		8'hB0, // 3
		8'h99, // 4
		8'h92, // 5
		8'h82, // 6
		8'hF8, // 7
		8'h80, // 8
		8'h90, // 9
		8'h88, // A
		8'h83, // b
		8'hA7, // c
		8'hA1, // d
		8'h84, // e
		8'h8E  // F
	};

	localparam glyph_t glyph_off = 8'hFF; // Every segment dark

endpackage
